// File: Bender.yml
package:
  name: fpu16

sources:
  - hdl/qfpu_isa_pkg.sv
  - hdl/fp16_pkg.sv
  - hdl/fpu_req_if.sv
  - hdl/fpu16_issue.sv
  - hdl/int_logic_unit.sv
  - hdl/fp16_class_unit.sv
  - hdl/fp16_pipe_unit.sv
  - hdl/fpu16_retire.sv
  - hdl/fpu16_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/fpu16_tb.sv

// File: include/fpu16_model.svh
// Behavioral reference for one instruction of the execution unit.
// Include inside a module after qfpu_isa_pkg and fp16_pkg are compiled.
// Floats are handled through integer keys and shifts, not through real numbers.

`ifndef FPU16_MODEL_SVH
`define FPU16_MODEL_SVH

function automatic qfpu_isa_pkg::word_t expected_result(
	qfpu_isa_pkg::instruction_t ir,
	qfpu_isa_pkg::word_t a,
	qfpu_isa_pkg::word_t b,
	qfpu_isa_pkg::word_t c,
	qfpu_isa_pkg::word_t i
);
	qfpu_isa_pkg::opcode_t opc;
	qfpu_isa_pkg::func_t   fn;
	qfpu_isa_pkg::sub_t    sub;
	logic [15:0] ab;
	logic [15:0] mag;
	int ea;
	int sum;
	int ka;
	int kb;
	logic nan_a;
	logic nan_b;
	opc   = qfpu_isa_pkg::ir_opcode(ir);
	fn    = qfpu_isa_pkg::ir_func(ir);
	sub   = qfpu_isa_pkg::ir_sub(ir);
	ea    = a[14:10];
	nan_a = (a[14:10] == 5'h1F) && (a[9:0] != 0);
	nan_b = (b[14:10] == 5'h1F) && (b[9:0] != 0);
	// Ordering keys treat both zeros as the same value
	ka    = a[15] ? -int'(a[14:0]) : int'(a[14:0]);
	kb    = b[15] ? -int'(b[14:0]) : int'(b[14:0]);
	case (opc)
		qfpu_isa_pkg::OP_ADDI: return a + i;
		qfpu_isa_pkg::OP_ANDI: return a & i;
		qfpu_isa_pkg::OP_ORI:  return a | i;
		qfpu_isa_pkg::OP_EORI: return a ^ i;
		qfpu_isa_pkg::OP_MOV:  return a;
		qfpu_isa_pkg::OP_R3: begin
			if (fn == qfpu_isa_pkg::FN_SUB) return a - b - c;
			if (fn == qfpu_isa_pkg::FN_MVVR) return a;
			if (fn == qfpu_isa_pkg::FN_OR && sub == 3'd7) return (a & b) | (a & c) | (b & c);
			case (fn)
				qfpu_isa_pkg::FN_ADD: ab = a + b;
				qfpu_isa_pkg::FN_AND: ab = a & b;
				qfpu_isa_pkg::FN_OR:  ab = a | b;
				qfpu_isa_pkg::FN_EOR: ab = a ^ b;
				default: return 16'd0;
			endcase
			if (sub == 3'd0) return ab & c;
			if (sub == 3'd1) return ab | c;
			if (sub == 3'd2) return ab ^ c;
			if (sub == 3'd3 && fn == qfpu_isa_pkg::FN_ADD) return ab + c;
			return 16'd0;
		end
		qfpu_isa_pkg::OP_FLT: begin
			case (fn)
				qfpu_isa_pkg::FN_FABS:   return {1'b0, a[14:0]};
				qfpu_isa_pkg::FN_FNEG:   return {~a[15], a[14:0]};
				qfpu_isa_pkg::FN_FSIGN:
					return (nan_a || a[14:0] == 0) ? a : {a[15], fp16_pkg::FP_ONE[14:0]};
				qfpu_isa_pkg::FN_ISNAN:  return {15'd0, nan_a};
				qfpu_isa_pkg::FN_FINITE: return {15'd0, ea != 31};
				qfpu_isa_pkg::FN_SGNJ:   return {a[15], b[14:0]};
				qfpu_isa_pkg::FN_SGNJN:  return {~a[15], b[14:0]};
				qfpu_isa_pkg::FN_SGNJX:  return {a[15] ^ b[15], b[14:0]};
				qfpu_isa_pkg::FN_FSEQ:   return {15'd0, !nan_a && !nan_b && ka == kb};
				qfpu_isa_pkg::FN_FSLT:   return {15'd0, !nan_a && !nan_b && ka < kb};
				qfpu_isa_pkg::FN_FSLE:   return {15'd0, !nan_a && !nan_b && ka <= kb};
				qfpu_isa_pkg::FN_FTRUNC: begin
					if (ea < 15) return {a[15], 15'd0};
					if (ea >= 25) return a;
					return a & ~((16'd1 << (25 - ea)) - 16'd1);
				end
				qfpu_isa_pkg::FN_FTOI: begin
					if (nan_a || ea < 15) return 16'd0;
					if (ea >= 30) return a[15] ? 16'h8000 : 16'h7FFF;
					mag = (ea >= 25) ? ({5'd0, 1'b1, a[9:0]} << (ea - 25))
						: ({5'd0, 1'b1, a[9:0]} >> (25 - ea));
					return a[15] ? -mag : mag;
				end
				qfpu_isa_pkg::FN_FSCALEB: begin
					if (ea == 31) return a;
					sum = ea + int'($signed(b));
					if (ea == 0 || sum <= 0) return {a[15], 15'd0};
					if (sum >= 31) return {a[15], fp16_pkg::FP_PINF[14:0]};
					return {a[15], 5'(sum), a[9:0]};
				end
				default: return 16'd0;
			endcase
		end
		default: return 16'd0;
	endcase
endfunction

`endif

// File: bench/fpu16_tb.sv
// Testbench for the 16-bit execution unit.
// Inputs change on falling edges and outputs are sampled on falling edges.
// Each vector is held until the checker has seen done and compared o.
// A vector that repeats the previous one gets bit 0 of a flipped to force a restart.

`timescale 1ns/1ps

module fpu16_tb;
	import qfpu_isa_pkg::*;
	import fp16_pkg::*;

	`include "fpu16_model.svh"

	localparam int N_INT   = 200;
	localparam int N_CLASS = 96;
	localparam int N_PIPE  = 60;
	localparam int N_INTR  = 12;
	// Reset vector, directed compares and directed pipe cases, two vectors per interrupt
	localparam int N_VEC      = 1 + N_INT + 8 + N_CLASS + 12 + N_PIPE + 2 * N_INTR;
	localparam int DONE_LIMIT = 12;

	logic         clk;
	logic         rst;
	instruction_t ir;
	word_t        a;
	word_t        b;
	word_t        c;
	word_t        i;
	word_t        o;
	logic         done;

	int          seed;
	int          err_cnt;
	int          chk_cnt;
	int          k;
	word_t       exp_o;
	int          exp_lat;
	logic [87:0] last_vec;
	logic        prev_done;
	word_t       prev_o;
	event        vec_sent;
	event        vec_checked;

	opcode_t int_opc [8]   = '{OP_R3, OP_ADDI, OP_ANDI, OP_ORI, OP_EORI, OP_MOV, OP_NOP, 7'h55};
	func_t   r3_fn [6]     = '{FN_ADD, FN_AND, FN_OR, FN_EOR, FN_SUB, FN_MVVR};
	func_t   pipe_fn [3]   = '{FN_FTRUNC, FN_FTOI, FN_FSCALEB};
	func_t   class_fn [11] = '{FN_FABS, FN_FNEG, FN_FSIGN, FN_ISNAN, FN_FINITE, FN_FSEQ,
		FN_FSLT, FN_FSLE, FN_SGNJ, FN_SGNJN, FN_SGNJX};
	// Signed zeros, infinities, quiet NaNs, plus and minus one, largest finite, a subnormal
	fp16_t   specials [10] = '{16'h0000, 16'h8000, 16'h7C00, 16'hFC00, 16'h7E00, 16'hFE00,
		16'h3C00, 16'hBC00, 16'h7BFF, 16'h0001};
	// Directed pipe cases for saturation, overflow to infinity and flush to zero
	func_t   dir_fn [12]   = '{FN_FTRUNC, FN_FTRUNC, FN_FTRUNC, FN_FTRUNC, FN_FTOI, FN_FTOI,
		FN_FTOI, FN_FTOI, FN_FSCALEB, FN_FSCALEB, FN_FSCALEB, FN_FSCALEB};
	fp16_t   dir_a [12]    = '{16'h3E00, 16'h3800, 16'hB800, 16'h4A40, 16'h7BFF, 16'hFBFF,
		16'h7E00, 16'hC500, 16'h3C00, 16'hBC00, 16'h3C00, 16'hFC00};
	word_t   dir_b [12]    = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
		16'h0000, 16'h0000, 16'h0010, 16'hFFF1, 16'h0003, 16'h0005};

	fpu16_top DUT (
		.clk(clk),
		.rst(rst),
		.ir(ir),
		.a(a),
		.b(b),
		.c(c),
		.i(i),
		.o(o),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ========================================
	// Helpers
	// ========================================
	function automatic word_t rand_word();
		return word_t'($random(seed));
	endfunction

	function automatic fp16_t pick_half();
		if ($random(seed) & 1)
			return specials[$unsigned($random(seed)) % 10];
		return fp16_t'($random(seed));
	endfunction

	function automatic instruction_t make_ir(opcode_t opc, func_t fn, sub_t sub);
		instruction_t w;
		w = '0;
		// Bits above the sub-operation field are not decoded
		w[23:16]           = 8'($random(seed));
		w[OPC_MSB:OPC_LSB] = opc;
		w[FN_MSB:FN_LSB]   = fn;
		w[SUB_MSB:SUB_LSB] = sub;
		return w;
	endfunction

	// Fast results show done two edges after capture, the pipe four
	function automatic int latency_of(instruction_t w);
		func_t fn;
		fn = w[FN_MSB:FN_LSB];
		if (w[OPC_MSB:OPC_LSB] == OP_FLT &&
			(fn == FN_FTRUNC || fn == FN_FTOI || fn == FN_FSCALEB))
			return 4;
		return 2;
	endfunction

	task automatic drive_inputs(instruction_t n_ir, word_t n_a, word_t n_b, word_t n_c,
		word_t n_i);
		if ({n_ir, n_a, n_b, n_c, n_i} == last_vec)
			n_a[0] = ~n_a[0];
		ir       = n_ir;
		a        = n_a;
		b        = n_b;
		c        = n_c;
		i        = n_i;
		last_vec = {n_ir, n_a, n_b, n_c, n_i};
	endtask

	// Drives one vector and blocks until the checker has finished with it
	task automatic send_vector(instruction_t n_ir, word_t n_a, word_t n_b, word_t n_c,
		word_t n_i);
		drive_inputs(n_ir, n_a, n_b, n_c, n_i);
		exp_o   = expected_result(ir, a, b, c, i);
		exp_lat = latency_of(ir);
		-> vec_sent;
		@(vec_checked);
	endtask

	// ========================================
	// Checker
	// ========================================
	initial begin : result_check
		int n;
		forever begin
			@(vec_sent);
			@(posedge clk);
			@(posedge clk);
			@(negedge clk);
			if (done) begin
				$display("done still high in the cycle after the restart at %0t", $time);
				err_cnt++;
			end
			n = 1;
			while (!done && n < DONE_LIMIT) begin
				@(negedge clk);
				n++;
			end
			chk_cnt++;
			if (!done) begin
				$display("done never rose for instruction %h at %0t", ir, $time);
				err_cnt++;
			end else begin
				if (n != exp_lat) begin
					$display("done rose %0d cycles after capture instead of %0d at %0t",
						n, exp_lat, $time);
					err_cnt++;
				end
				if (o !== exp_o) begin
					$display("ERR %0t o expected %h actual %h", $time, exp_o, o);
					err_cnt++;
				end
			end
			-> vec_checked;
		end
	end

	// While done stays high the result must not move
	always @(negedge clk) begin
		if (!rst && done && prev_done && o !== prev_o) begin
			$display("ERR %0t o expected %h actual %h", $time, prev_o, o);
			err_cnt++;
		end
		prev_done = done;
		prev_o    = o;
	end

	initial begin
		repeat (N_VEC * 10 + 100) @(posedge clk);
		$display("watchdog expired before all vectors were checked, %0d errors", err_cnt);
		$display("sim failed");
		$finish;
	end

	// ========================================
	// Stimulus
	// ========================================
	initial begin
		seed     = 87476;
		err_cnt  = 0;
		chk_cnt  = 0;
		last_vec = '0;
		rst      = 1'b1;
		ir       = '0;
		a        = '0;
		b        = '0;
		c        = '0;
		i        = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (done !== 1'b0) begin
			$display("ERR %0t done expected 0 actual %b", $time, done);
			err_cnt++;
		end
		if (o !== 16'h0000) begin
			$display("ERR %0t o expected 0000 actual %h", $time, o);
			err_cnt++;
		end
		// The first vector goes out together with the reset release
		rst = 1'b0;
		send_vector(make_ir(OP_ADDI, 6'd0, 3'd0), 16'h1234, '0, '0, 16'h0101);

		// Every selector under each two-operand function, then random integer work
		for (k = 0; k < N_INT; k++) begin
			@(negedge clk);
			if (k < 32)
				send_vector(make_ir(OP_R3, r3_fn[k / 8], sub_t'(k % 8)),
					rand_word(), rand_word(), rand_word(), rand_word());
			else
				send_vector(make_ir(int_opc[$unsigned($random(seed)) % 8],
					r3_fn[$unsigned($random(seed)) % 6], sub_t'(rand_word())),
					rand_word(), rand_word(), rand_word(), rand_word());
		end

		// Signed zeros compare equal and any NaN makes a compare false
		@(negedge clk);
		send_vector(make_ir(OP_FLT, FN_FSEQ, 3'd0), 16'h0000, 16'h8000, '0, '0);
		@(negedge clk);
		send_vector(make_ir(OP_FLT, FN_FSLT, 3'd0), 16'h8000, 16'h0000, '0, '0);
		@(negedge clk);
		send_vector(make_ir(OP_FLT, FN_FSLE, 3'd0), 16'h0000, 16'h8000, '0, '0);
		@(negedge clk);
		send_vector(make_ir(OP_FLT, FN_FSLT, 3'd0), 16'h7E00, 16'h3C00, '0, '0);
		@(negedge clk);
		send_vector(make_ir(OP_FLT, FN_FSLE, 3'd0), 16'h3C00, 16'hFE00, '0, '0);
		@(negedge clk);
		send_vector(make_ir(OP_FLT, FN_FSEQ, 3'd0), 16'h7C00, 16'h7C00, '0, '0);
		@(negedge clk);
		send_vector(make_ir(OP_FLT, FN_FSLT, 3'd0), 16'hFC00, 16'h7C00, '0, '0);
		@(negedge clk);
		send_vector(make_ir(OP_FLT, FN_FSLT, 3'd0), 16'hBC00, 16'hC000, '0, '0);
		for (k = 0; k < N_CLASS; k++) begin
			@(negedge clk);
			send_vector(make_ir(OP_FLT, class_fn[k % 11], 3'd0),
				pick_half(), pick_half(), '0, '0);
		end

		for (k = 0; k < 12; k++) begin
			@(negedge clk);
			send_vector(make_ir(OP_FLT, dir_fn[k], 3'd0), dir_a[k], dir_b[k], '0, '0);
		end
		// Scale amounts stay small enough that normal results also occur
		for (k = 0; k < N_PIPE; k++) begin
			@(negedge clk);
			send_vector(make_ir(OP_FLT, pipe_fn[k % 3], 3'd0), pick_half(),
				word_t'($random(seed) % 24), '0, '0);
		end

		// A second vector lands one or two cycles into a pipe operation
		for (k = 0; k < N_INTR; k++) begin
			@(negedge clk);
			drive_inputs(make_ir(OP_FLT, pipe_fn[k % 3], 3'd0), pick_half(),
				word_t'($random(seed) % 24), '0, '0);
			repeat (1 + k % 2) @(negedge clk);
			if (k % 2 == 1 && done !== 1'b0) begin
				$display("done did not drop two cycles after a new vector at %0t", $time);
				err_cnt++;
			end
			if (k < N_INTR / 2)
				send_vector(make_ir(OP_FLT, pipe_fn[(k + 1) % 3], 3'd0), pick_half(),
					word_t'($random(seed) % 24), '0, '0);
			else
				send_vector(make_ir(OP_R3, FN_ADD, 3'd3), rand_word(), rand_word(),
					rand_word(), rand_word());
		end

		@(negedge clk);
		$display("%0d vectors checked, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: hdl/fp16_class_unit.sv
// Half-precision sign, class, sign-inject and compare operations.
// Combinational from the captured operands. Compares return 1 or 0 and any
// NaN operand makes them all false. Plus and minus zero compare equal.

`timescale 1ns/1ps

module fp16_class_unit (
	fpu_req_if.unit             req,
	output qfpu_isa_pkg::word_t class_res
);
	import qfpu_isa_pkg::*;
	import fp16_pkg::*;

	func_t fn;
	fp16_t fa;
	fp16_t fb;
	logic  a_sgn;
	logic  b_sgn;
	logic  a_nan;
	logic  b_nan;
	logic  a_zero;
	logic  both_zero;
	logic  f_eq;
	logic  f_lt;

	assign fn    = ir_func(req.ir);
	assign fa    = req.a;
	assign fb    = req.b;
	assign a_sgn = fa[SIGN_BIT];
	assign b_sgn = fb[SIGN_BIT];

	// NaN has an all-ones exponent with a nonzero mantissa
	assign a_nan = &fa[EXP_MSB:EXP_LSB] && |fa[MAN_MSB:MAN_LSB];
	assign b_nan = &fb[EXP_MSB:EXP_LSB] && |fb[MAN_MSB:MAN_LSB];

	assign a_zero    = ~|fa[EXP_MSB:0];
	assign both_zero = a_zero && ~|fb[EXP_MSB:0];

	assign f_eq = !(a_nan || b_nan) && ((fa == fb) || both_zero);

	// Sign-magnitude ordering. Between two negatives the larger magnitude is less
	always_comb begin
		if (a_nan || b_nan || both_zero)
			f_lt = 1'b0;
		else if (a_sgn != b_sgn)
			f_lt = a_sgn;
		else if (a_sgn)
			f_lt = fb[EXP_MSB:0] < fa[EXP_MSB:0];
		else
			f_lt = fa[EXP_MSB:0] < fb[EXP_MSB:0];
	end

	always_comb begin
		case (fn)
			FN_FABS:   class_res = {1'b0, fa[EXP_MSB:0]};
			FN_FNEG:   class_res = {~a_sgn, fa[EXP_MSB:0]};
			FN_FSIGN:  class_res = (a_zero || a_nan) ? fa : {a_sgn, FP_ONE[EXP_MSB:0]};
			FN_ISNAN:  class_res = {15'd0, a_nan};
			FN_FINITE: class_res = {15'd0, ~&fa[EXP_MSB:EXP_LSB]};
			// Magnitude always comes from b
			FN_SGNJ:   class_res = {a_sgn, fb[EXP_MSB:0]};
			FN_SGNJN:  class_res = {~a_sgn, fb[EXP_MSB:0]};
			FN_SGNJX:  class_res = {a_sgn ^ b_sgn, fb[EXP_MSB:0]};
			FN_FSEQ:   class_res = {15'd0, f_eq};
			FN_FSLT:   class_res = {15'd0, f_lt};
			FN_FSLE:   class_res = {15'd0, f_lt | f_eq};
			default:   class_res = '0;
		endcase
	end

endmodule

// File: hdl/fp16_pipe_unit.sv
// Two-stage pipe for truncate, float-to-integer and scale-by.
// The result is valid two edges after new operands are captured.
// Subnormal inputs count as zero, and scale-by flushes subnormal results to zero.

`timescale 1ns/1ps

module fp16_pipe_unit (
	input  logic                clk,
	input  logic                rst,
	fpu_req_if.unit             req,
	output qfpu_isa_pkg::word_t pipe_res
);
	import qfpu_isa_pkg::*;
	import fp16_pkg::*;

	fp16_t fa;
	exp_t  ex;
	man_t  man;
	exp_t  frac_bits;

	// Stage one registers
	func_t              s1_fn;
	fp16_t              s1_a;
	logic               s1_nan;
	logic               s1_special;
	logic               s1_below;
	logic               s1_zero;
	logic               s1_big;
	man_t               s1_man;
	word_t              s1_mag;
	logic signed [17:0] s1_sum;

	assign fa  = req.a;
	assign ex  = fa[EXP_MSB:EXP_LSB];
	assign man = fa[MAN_MSB:MAN_LSB];

	// Fraction bits below the binary point, meaningful for exponents 15 to 25
	assign frac_bits = exp_t'(EXP_BIAS + MAN_W) - ex;

	// ========================================
	// Stage one decodes and aligns
	// ========================================
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			s1_fn <= '0;
		else
			s1_fn <= ir_func(req.ir);
	end

	always_ff @(posedge clk) begin
		s1_a       <= fa;
		s1_special <= &ex;
		s1_nan     <= &ex && |man;
		s1_below   <= ex < exp_t'(EXP_BIAS);
		s1_zero    <= ex == '0;
		// Magnitudes of 2^15 and up do not fit a signed 16-bit integer
		s1_big     <= ex >= exp_t'(EXP_BIAS + 15);
		// Clear the fraction bits, nothing to clear once the exponent reaches 25
		if (ex >= exp_t'(EXP_BIAS + MAN_W))
			s1_man <= man;
		else
			s1_man <= man & (man_t'('1) << frac_bits);
		// Integer magnitude of the hidden-one significand
		if (ex >= exp_t'(EXP_BIAS + MAN_W))
			s1_mag <= word_t'({1'b1, man}) << (ex - exp_t'(EXP_BIAS + MAN_W));
		else
			s1_mag <= word_t'({1'b1, man}) >> frac_bits;
		s1_sum <= $signed({13'd0, ex}) + $signed({{2{req.b[15]}}, req.b});
	end

	// ========================================
	// Stage two rounds toward zero and saturates
	// ========================================
	always_ff @(posedge clk) begin
		case (s1_fn)
			FN_FTRUNC: begin
				if (s1_below)
					pipe_res <= {s1_a[SIGN_BIT], 15'd0};
				else
					pipe_res <= {s1_a[SIGN_BIT:EXP_LSB], s1_man};
			end
			FN_FTOI: begin
				if (s1_nan || s1_below)
					pipe_res <= '0;
				else if (s1_big)
					pipe_res <= s1_a[SIGN_BIT] ? 16'h8000 : 16'h7FFF;
				else
					pipe_res <= s1_a[SIGN_BIT] ? -s1_mag : s1_mag;
			end
			FN_FSCALEB: begin
				if (s1_special)
					pipe_res <= s1_a;
				else if (s1_zero || s1_sum <= 18'sd0)
					pipe_res <= {s1_a[SIGN_BIT], 15'd0};
				else if (s1_sum >= 18'sd31)
					pipe_res <= {s1_a[SIGN_BIT], FP_PINF[EXP_MSB:0]};
				else
					pipe_res <= {s1_a[SIGN_BIT], s1_sum[EXP_W-1:0], s1_a[MAN_MSB:0]};
			end
			default: pipe_res <= '0;
		endcase
	end

	// Both stages have refilled from the new operands two cycles on
	assert property (@(posedge clk) disable iff (rst)
		req.restart |-> ##2 !$isunknown(pipe_res));

endmodule

// File: hdl/fp16_pkg.sv
// IEEE 754 half-precision format description.
// Only quiet NaNs are produced, and subnormals are treated as zero on input.

package fp16_pkg;

	localparam int EXP_W = 5;
	localparam int MAN_W = 10;

	typedef logic [15:0]      fp16_t;
	typedef logic [EXP_W-1:0] exp_t;
	typedef logic [MAN_W-1:0] man_t;

	localparam int EXP_BIAS = 15;

	// Bit positions inside an fp16_t
	localparam int SIGN_BIT = 15;
	localparam int EXP_MSB  = 14;
	localparam int EXP_LSB  = 10;
	localparam int MAN_MSB  = 9;
	localparam int MAN_LSB  = 0;

	// Plus one, plus infinity and the canonical quiet NaN
	localparam fp16_t FP_ONE  = 16'h3C00;
	localparam fp16_t FP_PINF = 16'h7C00;
	localparam fp16_t FP_QNAN = 16'h7E00;

endpackage

// File: hdl/fpu16_issue.sv
// Input capture for the execution unit.
// Inputs are sampled on every rising edge. Any difference from the last
// capture, or the first capture after reset, raises restart for one cycle.

`timescale 1ns/1ps

module fpu16_issue (
	input  logic                       clk,
	input  logic                       rst,
	input  qfpu_isa_pkg::instruction_t ir,
	input  qfpu_isa_pkg::word_t        a,
	input  qfpu_isa_pkg::word_t        b,
	input  qfpu_isa_pkg::word_t        c,
	input  qfpu_isa_pkg::word_t        i,
	fpu_req_if.src                     req
);
	import qfpu_isa_pkg::*;

	localparam int IN_W = $bits(instruction_t) + 4 * $bits(word_t);

	logic            primed;
	logic [IN_W-1:0] in_vec;
	logic [IN_W-1:0] cap_vec;
	logic            changed;

	// Live inputs and the last capture packed the same way for comparison
	assign in_vec  = {ir, a, b, c, i};
	assign cap_vec = {req.ir, req.a, req.b, req.c, req.i};
	assign changed = !primed || (in_vec != cap_vec);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			primed      <= 1'b0;
			req.ir      <= '0;
			req.a       <= '0;
			req.b       <= '0;
			req.c       <= '0;
			req.i       <= '0;
			req.restart <= 1'b0;
		end else begin
			primed      <= 1'b1;
			req.ir      <= ir;
			req.a       <= a;
			req.b       <= b;
			req.c       <= c;
			req.i       <= i;
			req.restart <= changed;
		end
	end

	// Inputs held steady across a restart must not start the unit again
	assert property (@(posedge clk) disable iff (rst)
		req.restart && (in_vec == cap_vec) |=> !req.restart);

endmodule

// File: hdl/fpu16_retire.sv
// Result selection and completion tracking.
// The result register loads every cycle. done rises once the latency of the
// captured operation has elapsed and stays high until the next restart.

`timescale 1ns/1ps

module fpu16_retire (
	input  logic                clk,
	input  logic                rst,
	fpu_req_if.sink             req,
	input  qfpu_isa_pkg::word_t int_res,
	input  qfpu_isa_pkg::word_t class_res,
	input  qfpu_isa_pkg::word_t pipe_res,
	output qfpu_isa_pkg::word_t o,
	output logic                done
);
	import qfpu_isa_pkg::*;

	lat_state_t state;
	logic [1:0] cnt;
	opcode_t    opc;
	func_t      fn;
	logic       is_flt;
	logic       is_pipe;
	word_t      sel;

	assign opc     = ir_opcode(req.ir);
	assign fn      = ir_func(req.ir);
	assign is_flt  = opc == OP_FLT;
	assign is_pipe = is_flt && (fn inside {FN_FTRUNC, FN_FTOI, FN_FSCALEB});

	// Pipe operations first, then the other float operations, then integer
	assign sel = is_pipe ? pipe_res : (is_flt ? class_res : int_res);

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			o <= '0;
		else
			o <= sel;
	end

	// ========================================
	// Latency FSM
	// ========================================
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= LS_IDLE;
			cnt   <= '0;
		end else if (req.restart) begin
			state <= LS_WAIT;
			cnt   <= is_pipe ? LAT_PIPE : LAT_FAST;
		end else begin
			case (state)
				LS_WAIT: begin
					if (cnt == 2'd1)
						state <= LS_DONE;
					else
						cnt <= cnt - 2'd1;
				end
				LS_IDLE: state <= LS_IDLE;
				LS_DONE: state <= LS_DONE;
				default: state <= LS_IDLE;
			endcase
		end
	end

	assign done = state == LS_DONE;

	// A restart always withdraws done before any new result can be seen
	assert property (@(posedge clk) disable iff (rst) req.restart |=> !done);

endmodule

// File: hdl/fpu16_top.sv
// 16-bit execution unit top level.
// Inputs must be held until done rises. Any input change restarts the unit
// and abandons the operation in flight.

`timescale 1ns/1ps

module fpu16_top (
	input  logic                       clk,
	input  logic                       rst,
	input  qfpu_isa_pkg::instruction_t ir,
	input  qfpu_isa_pkg::word_t        a,
	input  qfpu_isa_pkg::word_t        b,
	input  qfpu_isa_pkg::word_t        c,
	input  qfpu_isa_pkg::word_t        i,
	output qfpu_isa_pkg::word_t        o,
	output logic                       done
);
	import qfpu_isa_pkg::*;

	word_t int_res;
	word_t class_res;
	word_t pipe_res;

	fpu_req_if req ();

	fpu16_issue u_issue (
		.clk(clk),
		.rst(rst),
		.ir(ir),
		.a(a),
		.b(b),
		.c(c),
		.i(i),
		.req(req.src)
	);

	// Combinational units and the two-stage pipe all read the same capture
	int_logic_unit u_int (.req(req.unit), .int_res(int_res));
	fp16_class_unit u_class (.req(req.unit), .class_res(class_res));
	fp16_pipe_unit u_pipe (.clk(clk), .rst(rst), .req(req.unit), .pipe_res(pipe_res));

	fpu16_retire u_retire (
		.clk(clk),
		.rst(rst),
		.req(req.sink),
		.int_res(int_res),
		.class_res(class_res),
		.pipe_res(pipe_res),
		.o(o),
		.done(done)
	);

endmodule

// File: hdl/fpu_req_if.sv
// Captured request shared by the issue stage, the units and the retire stage.
// All signals are registered by the issue stage, and restart is one cycle wide.

`timescale 1ns/1ps

interface fpu_req_if;
	import qfpu_isa_pkg::*;

	instruction_t ir;
	word_t        a;
	word_t        b;
	word_t        c;
	word_t        i;
	// High for the one cycle after a new operand set was captured
	logic         restart;

	modport src (output ir, a, b, c, i, restart);
	modport unit (input ir, a, b, c, i, restart);
	modport sink (input ir, restart);

endinterface

// File: hdl/int_logic_unit.sv
// Three-operand integer and immediate operations.
// Purely combinational from the captured operands. Undefined encodings
// and unsupported sub-operation selectors give zero.

`timescale 1ns/1ps

module int_logic_unit (
	fpu_req_if.unit             req,
	output qfpu_isa_pkg::word_t int_res
);
	import qfpu_isa_pkg::*;

	opcode_t opc;
	func_t   fn;
	sub_t    sub;
	word_t   ab;
	word_t   maj;

	assign opc = ir_opcode(req.ir);
	assign fn  = ir_func(req.ir);
	assign sub = ir_sub(req.ir);

	// Bitwise majority of the three operands
	assign maj = (req.a & req.b) | (req.a & req.c) | (req.b & req.c);

	// First stage of the R3 forms combines a and b
	always_comb begin
		case (fn)
			FN_ADD:  ab = req.a + req.b;
			FN_AND:  ab = req.a & req.b;
			FN_OR:   ab = req.a | req.b;
			FN_EOR:  ab = req.a ^ req.b;
			default: ab = '0;
		endcase
	end

	always_comb begin
		int_res = '0;
		case (opc)
			OP_R3: begin
				case (fn)
					FN_ADD, FN_AND, FN_OR, FN_EOR: begin
						// The selector picks how c joins the partial result
						case (sub)
							3'd0: int_res = ab & req.c;
							3'd1: int_res = ab | req.c;
							3'd2: int_res = ab ^ req.c;
							3'd3: int_res = (fn == FN_ADD) ? ab + req.c : '0;
							3'd7: int_res = (fn == FN_OR) ? maj : '0;
							default: int_res = '0;
						endcase
					end
					FN_SUB:  int_res = req.a - req.b - req.c;
					FN_MVVR: int_res = req.a;
					default: int_res = '0;
				endcase
			end
			OP_ADDI: int_res = req.a + req.i;
			OP_ANDI: int_res = req.a & req.i;
			OP_ORI:  int_res = req.a | req.i;
			OP_EORI: int_res = req.a ^ req.i;
			OP_MOV:  int_res = req.a;
			OP_NOP:  int_res = '0;
			default: int_res = '0;
		endcase
	end

endmodule

// File: hdl/qfpu_isa_pkg.sv
// Instruction encoding for the 16-bit execution unit.
// The instruction word is 24 bits. Only opcode, function and sub-operation
// fields are decoded, and the remaining upper bits are ignored.
// Latencies count cycles from the restart pulse to a valid result.

package qfpu_isa_pkg;

	typedef logic [23:0] instruction_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [5:0]  func_t;
	typedef logic [2:0]  sub_t;
	typedef logic [15:0] word_t;

	// ========================================
	// Field positions
	// ========================================
	localparam int OPC_LSB = 0;
	localparam int OPC_MSB = 6;
	localparam int FN_LSB  = 7;
	localparam int FN_MSB  = 12;
	localparam int SUB_LSB = 13;
	localparam int SUB_MSB = 15;

	// Opcodes. Zero is left undefined so a cleared capture decodes to nothing
	localparam opcode_t OP_R3   = 7'h02;
	localparam opcode_t OP_ADDI = 7'h04;
	localparam opcode_t OP_ANDI = 7'h08;
	localparam opcode_t OP_ORI  = 7'h09;
	localparam opcode_t OP_EORI = 7'h0A;
	localparam opcode_t OP_MOV  = 7'h12;
	localparam opcode_t OP_NOP  = 7'h1F;
	localparam opcode_t OP_FLT  = 7'h2C;

	// Integer function codes used under OP_R3
	localparam func_t FN_ADD  = 6'h04;
	localparam func_t FN_SUB  = 6'h05;
	localparam func_t FN_AND  = 6'h08;
	localparam func_t FN_OR   = 6'h09;
	localparam func_t FN_EOR  = 6'h0A;
	localparam func_t FN_MVVR = 6'h0D;

	// Half-precision function codes used under OP_FLT
	localparam func_t FN_FABS    = 6'h20;
	localparam func_t FN_FNEG    = 6'h21;
	localparam func_t FN_FSIGN   = 6'h22;
	localparam func_t FN_ISNAN   = 6'h23;
	localparam func_t FN_FINITE  = 6'h24;
	localparam func_t FN_FTRUNC  = 6'h25;
	localparam func_t FN_FTOI    = 6'h26;
	localparam func_t FN_FSCALEB = 6'h28;
	localparam func_t FN_FSEQ    = 6'h30;
	localparam func_t FN_FSLT    = 6'h31;
	localparam func_t FN_FSLE    = 6'h32;
	localparam func_t FN_SGNJ    = 6'h34;
	localparam func_t FN_SGNJN   = 6'h35;
	localparam func_t FN_SGNJX   = 6'h36;

	// Latency of the combinational units and of the two-stage pipe
	localparam logic [1:0] LAT_FAST = 2'd1;
	localparam logic [1:0] LAT_PIPE = 2'd3;

	typedef enum logic [1:0] {
		LS_IDLE,
		LS_WAIT,
		LS_DONE
	} lat_state_t;

	// ========================================
	// Field extraction
	// ========================================
	function automatic opcode_t ir_opcode(instruction_t ir);
		return ir[OPC_MSB:OPC_LSB];
	endfunction

	function automatic func_t ir_func(instruction_t ir);
		return ir[FN_MSB:FN_LSB];
	endfunction

	function automatic sub_t ir_sub(instruction_t ir);
		return ir[SUB_MSB:SUB_LSB];
	endfunction

endpackage

// File: src.f
+incdir+include
hdl/qfpu_isa_pkg.sv
hdl/fp16_pkg.sv
hdl/fpu_req_if.sv
hdl/fpu16_issue.sv
hdl/int_logic_unit.sv
hdl/fp16_class_unit.sv
hdl/fp16_pipe_unit.sv
hdl/fpu16_retire.sv
hdl/fpu16_top.sv
bench/fpu16_tb.sv
